/* src.f */
source/spart_drv_pkg.sv
source/spart_bus_if.sv
source/cursor_counter.sv
source/io_port.sv
source/driver_fsm.sv
source/spart_driver.sv
bench/tb_spart_driver.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_spart_driver
FILELIST   := src.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_spart_driver.sv */
`default_nettype none

module tb_spart_driver;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TESTS      = 9;
	localparam int IDLE_TIMEOUT = 400;

	logic       clk;
	logic       rst;
	logic [1:0] br_cfg;
	logic       rda;
	logic       tbr;
	logic       iocs;
	logic       iorw;
	logic [1:0] ioaddr;
	wire  [7:0] databus;

	// Peripheral side of the bus
	logic [7:0]  key_drv;
	logic [31:0] lcg_state;

	// Bytes seen on the bus, divisor entries carry the address on top
	logic [7:0] tx_q [$];
	logic [9:0] div_q [$];

	// Test in progress, shown in error lines
	string cur_test;

	// Divisor bytes per br_cfg
	logic [7:0] exp_db_low  [4] = '{8'hc0, 8'h80, 8'h00, 8'h00};
	logic [7:0] exp_db_high [4] = '{8'h12, 8'h25, 8'h4b, 8'h96};

	//////////////////////////////
	// Console stimulus table
	//////////////////////////////

	string test_name [N_TESTS] = '{
		"dump_from_zero", "dump_at_limit", "dec_echo", "dump_from_nine", "inc_echo",
		"dump_past_limit", "unknown_key", "dec_back", "dump_at_ten"
	};
	logic [7:0] test_key [N_TESTS] = '{
		8'h0d, 8'h0d, 8'h31, 8'h0d, 8'h32, 8'h0d, 8'h78, 8'h31, 8'h0d
	};
	string exp_tx [N_TESTS] = '{
		"0 1 2 3 4 5 6 7 8 9 ", "", " ", "9 ", " ", "", "", " ", ""
	};
	int exp_len [N_TESTS] = '{20, 0, 1, 2, 1, 0, 0, 1, 0};

	spart_driver i_dut (
		.clk     (clk),
		.rst     (rst),
		.br_cfg  (br_cfg),
		.rda     (rda),
		.tbr     (tbr),
		.iocs    (iocs),
		.iorw    (iorw),
		.ioaddr  (ioaddr),
		.databus (databus)
	);

	// Peripheral drives the bus only with rda up
	assign databus = rda ? key_drv : {8{1'bz}};

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Random transmit stalls, about one cycle in four
	always @(posedge clk) begin
		#1;
		lcg_state = lcg_next(lcg_state);
		tbr = (lcg_state[17:16] != 2'b00);
	end

	//////////////////////////////
	// Checks and waits
	//////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Idle means RX_WAIT with no key pending, the only time iocs drops
	task automatic wait_idle(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (iocs !== 1'b0) begin
			n++;
			if (n > IDLE_TIMEOUT) begin
				abort_run($sformatf("Timed out waiting for the driver to go idle (%s)", what));
			end
			@(negedge clk);
		end
	endtask

	task automatic reset_with_cfg(input logic [1:0] cfg);
		@(posedge clk);
		#1;
		rst = 1'b1;
		br_cfg = cfg;
		// Bus released and chip selected while reset is held
		@(negedge clk);
		check_value({cur_test, "_rst_iocs"}, 32'd1, 32'(iocs));
		check_value({cur_test, "_rst_iorw"}, 32'd1, 32'(iorw));
		check_value({cur_test, "_rst_bus"}, {24'd0, {8{1'bz}}}, 32'(databus));
		repeat (3) @(posedge clk);
		#1;
		tx_q.delete();
		div_q.delete();
		rst = 1'b0;
	endtask

	// One cycle of rda with the key on the bus
	task automatic send_key(input logic [7:0] key);
		@(posedge clk);
		#1;
		key_drv = key;
		rda = 1'b1;
		// Chip select held while the key is offered
		@(negedge clk);
		check_value({cur_test, "_key_iocs"}, 32'd1, 32'(iocs));
		@(posedge clk);
		#1;
		rda = 1'b0;
		key_drv = 8'h00;
	endtask

	// Bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (iorw === 1'b0) begin
				check_value({cur_test, "_tx_addr"}, 32'd0, 32'(ioaddr));
				if ($isunknown(databus)) begin
					abort_run("Transmit cycle with an undriven data bus");
				end
				tx_q.push_back(databus);
			end else if (iocs === 1'b1 && (ioaddr == 2'd2 || ioaddr == 2'd3)
					&& !$isunknown(databus)) begin
				div_q.push_back({ioaddr, databus});
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int i;
		int j;
		rst = 1'b1;
		br_cfg = 2'd0;
		rda = 1'b0;
		tbr = 1'b1;
		key_drv = 8'h00;
		lcg_state = 32'h55a;
		cur_test = "reset";

		// Divisor setup for every baud setting
		for (i = 0; i < 4; i++) begin
			cur_test = $sformatf("baud_cfg%0d", i);
			reset_with_cfg(2'(i));
			// Low byte in the first cycle after reset, high byte in the second
			@(negedge clk);
			check_value({cur_test, "_addr_low"}, 32'd2, 32'(ioaddr));
			check_value({cur_test, "_bus_low"}, 32'(exp_db_low[i]), 32'(databus));
			@(negedge clk);
			check_value({cur_test, "_addr_high"}, 32'd3, 32'(ioaddr));
			check_value({cur_test, "_bus_high"}, 32'(exp_db_high[i]), 32'(databus));
			// Waiting for keys from the third cycle
			@(negedge clk);
			check_value({cur_test, "_idle"}, 32'd0, 32'(iocs));
			check_value({cur_test, "_writes"}, 32'd2, 32'(div_q.size()));
			check_value({cur_test, "_low"},
				{22'd0, 2'd2, exp_db_low[i]}, 32'(div_q[0]));
			check_value({cur_test, "_high"},
				{22'd0, 2'd3, exp_db_high[i]}, 32'(div_q[1]));
			check_value({cur_test, "_tx"}, 32'd0, 32'(tx_q.size()));
		end

		// Console keys from cursor zero
		for (i = 0; i < N_TESTS; i++) begin
			cur_test = test_name[i];
			wait_idle({"before ", test_name[i]});
			tx_q.delete();
			send_key(test_key[i]);
			wait_idle(test_name[i]);
			check_value({test_name[i], "_len"}, 32'(exp_len[i]), 32'(tx_q.size()));
			for (j = 0; j < exp_len[i]; j++) begin
				check_value($sformatf("%s_byte%0d", test_name[i], j),
					32'(exp_tx[i][j]), 32'(tx_q[j]));
			end
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/spart_driver.sv */
`default_nettype none

module spart_driver (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [1:0]                        br_cfg,
	input  logic                              rda,
	input  logic                              tbr,
	output logic                              iocs,
	output logic                              iorw,
	output logic [1:0]                        ioaddr,
	inout  wire  [spart_drv_pkg::DATA_W-1:0]  databus
);
	import spart_drv_pkg::*;

	logic              inc;
	logic              dec;
	logic              at_limit;
	logic [DATA_W-1:0] digit;
	logic [DATA_W-1:0] tx_byte;

	spart_bus_if bus ();

	//////////////////////////////
	// Controller, port, cursor
	//////////////////////////////

	driver_fsm i_fsm (
		.clk      (clk),
		.rst      (rst),
		.rda      (rda),
		.tbr      (tbr),
		.at_limit (at_limit),
		.bus      (bus.ctrl),
		.inc      (inc),
		.dec      (dec)
	);

	io_port i_port (
		.br_cfg  (br_cfg),
		.digit   (digit),
		.bus     (bus.port),
		.rx_byte (databus),
		.tx_byte (tx_byte),
		.iocs    (iocs),
		.iorw    (iorw),
		.ioaddr  (ioaddr)
	);

	cursor_counter i_cursor (
		.clk      (clk),
		.rst      (rst),
		.inc      (inc),
		.dec      (dec),
		.digit    (digit),
		.at_limit (at_limit)
	);

	// Tri-state data bus, released unless writing
	assign databus = bus.drive ? tx_byte : {DATA_W{1'bz}};

endmodule

`default_nettype wire

/* source/driver_fsm.sv */
`default_nettype none

module driver_fsm (
	input  logic         clk,
	input  logic         rst,
	input  logic         rda,
	input  logic         tbr,
	input  logic         at_limit,
	spart_bus_if.ctrl    bus,
	output logic         inc,
	output logic         dec
);
	import spart_drv_pkg::*;

	driver_state_t state;
	driver_state_t next_state;

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= BAUD_LOW;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////
	// Next state and bus request
	//////////////////////////////

	always_comb begin
		// Idle defaults: bus released, chip selected
		next_state    = state;
		bus.drive     = 1'b0;
		bus.tx_strobe = 1'b0;
		bus.cs_idle   = 1'b0;
		bus.byte_src  = SRC_SPACE;
		inc           = 1'b0;
		dec           = 1'b0;

		case (state)
			// Divisor low byte, bus released while reset is held
			BAUD_LOW: begin
				bus.byte_src = SRC_BAUD_LOW;
				bus.drive    = ~rst;
				next_state   = BAUD_HIGH;
			end

			// Divisor high byte
			BAUD_HIGH: begin
				bus.byte_src = SRC_BAUD_HIGH;
				bus.drive    = 1'b1;
				next_state   = RX_WAIT;
			end

			// Wait for a key from the peripheral
			RX_WAIT: begin
				bus.cs_idle = ~rda;
				if (rda) begin
					case (bus.cmd)
						CMD_DUMP: next_state = DUMP_INDEX;
						CMD_DEC: begin
							dec        = 1'b1;
							next_state = ECHO_SEP;
						end
						CMD_INC: begin
							inc        = 1'b1;
							next_state = ECHO_SEP;
						end
						default: next_state = RX_WAIT;
					endcase
				end
			end

			// Index digit, or leave when the cursor is past the end
			DUMP_INDEX: begin
				bus.byte_src = SRC_INDEX;
				if (at_limit) begin
					next_state = RX_WAIT;
				end else if (tbr) begin
					bus.drive     = 1'b1;
					bus.tx_strobe = 1'b1;
					next_state    = DUMP_SEP;
				end
			end

			// Space after the digit, then step the cursor
			DUMP_SEP: begin
				if (tbr) begin
					bus.drive     = 1'b1;
					bus.tx_strobe = 1'b1;
					inc           = 1'b1;
					next_state    = DUMP_INDEX;
				end
			end

			// Echo for the cursor keys
			ECHO_SEP: begin
				if (tbr) begin
					bus.drive     = 1'b1;
					bus.tx_strobe = 1'b1;
					next_state    = RX_WAIT;
				end
			end

			default: next_state = BAUD_LOW;
		endcase
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// A transmit always owns the data bus
	a_tx_drives: assert property (@(posedge clk) disable iff (rst)
		bus.tx_strobe |-> bus.drive);

endmodule

`default_nettype wire

/* source/io_port.sv */
`default_nettype none

module io_port (
	input  logic [1:0]                        br_cfg,
	input  logic [spart_drv_pkg::DATA_W-1:0]  digit,
	spart_bus_if.port                         bus,
	input  logic [spart_drv_pkg::DATA_W-1:0]  rx_byte,
	output logic [spart_drv_pkg::DATA_W-1:0]  tx_byte,
	output logic                              iocs,
	output logic                              iorw,
	output logic [1:0]                        ioaddr
);
	import spart_drv_pkg::*;

	// Strobes, chip select is released only while idle
	assign iocs = ~bus.cs_idle;
	assign iorw = ~bus.tx_strobe;

	// Register address and outgoing byte per source
	always_comb begin
		case (bus.byte_src)
			SRC_BAUD_LOW: begin
				ioaddr  = IOADDR_DB_LOW;
				tx_byte = BAUD_DB_LOW[br_cfg];
			end
			SRC_BAUD_HIGH: begin
				ioaddr  = IOADDR_DB_HIGH;
				tx_byte = BAUD_DB_HIGH[br_cfg];
			end
			SRC_INDEX: begin
				ioaddr  = IOADDR_DATA;
				tx_byte = digit;
			end
			default: begin
				ioaddr  = IOADDR_DATA;
				tx_byte = CHAR_SPACE;
			end
		endcase
	end

	// Key decode, the FSM qualifies it with rda
	always_comb begin
		case (rx_byte)
			KEY_ENTER: bus.cmd = CMD_DUMP;
			KEY_DEC:   bus.cmd = CMD_DEC;
			KEY_INC:   bus.cmd = CMD_INC;
			default:   bus.cmd = CMD_NONE;
		endcase
	end

	// Transmit cycles go to the data register on a driven bus
	always_comb begin
		if (!iorw) begin
			a_tx_data_addr: assert final (ioaddr == IOADDR_DATA && bus.drive);
		end
	end

endmodule

`default_nettype wire

/* source/cursor_counter.sv */
`default_nettype none

module cursor_counter (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              inc,
	input  logic                              dec,
	output logic [spart_drv_pkg::DATA_W-1:0]  digit,
	output logic                              at_limit
);
	import spart_drv_pkg::*;

	logic [DATA_W-1:0] count;

	// Wrapping cursor
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (inc) begin
			count <= count + 1'b1;
		end else if (dec) begin
			count <= count - 1'b1;
		end
	end

	// ASCII only makes sense below ten
	assign digit    = count + ASCII_ZERO;
	assign at_limit = (count >= DUMP_LIMIT);

	// FSM never steps both ways in one cycle
	a_one_step: assert property (@(posedge clk) disable iff (rst)
		!(inc && dec));

endmodule

`default_nettype wire

/* source/spart_bus_if.sv */
`default_nettype none

interface spart_bus_if;
	import spart_drv_pkg::*;

	// Bus-cycle request from the controller
	logic         drive;
	logic         tx_strobe;
	logic         cs_idle;
	byte_src_t    byte_src;

	// Decoded received byte, valid only when rda is high
	console_cmd_t cmd;

	modport ctrl (
		output drive,
		output tx_strobe,
		output cs_idle,
		output byte_src,
		input  cmd
	);

	modport port (
		input  drive,
		input  tx_strobe,
		input  cs_idle,
		input  byte_src,
		output cmd
	);

endinterface

`default_nettype wire

/* source/spart_drv_pkg.sv */
`default_nettype none

package spart_drv_pkg;

	//////////////////////////////
	// Widths and types
	//////////////////////////////

	localparam int DATA_W = 8;

	// Console controller states
	typedef enum logic [3:0] {
		BAUD_LOW   = 4'd0,
		BAUD_HIGH  = 4'd1,
		RX_WAIT    = 4'd2,
		DUMP_INDEX = 4'd3,
		DUMP_SEP   = 4'd4,
		ECHO_SEP   = 4'd5
	} driver_state_t;

	// Meaning of a received byte
	typedef enum logic [1:0] {
		CMD_NONE = 2'd0,
		CMD_DUMP = 2'd1,
		CMD_DEC  = 2'd2,
		CMD_INC  = 2'd3
	} console_cmd_t;

	// Byte placed on the bus in a write cycle
	typedef enum logic [1:0] {
		SRC_BAUD_LOW  = 2'd0,
		SRC_BAUD_HIGH = 2'd1,
		SRC_INDEX     = 2'd2,
		SRC_SPACE     = 2'd3
	} byte_src_t;

	//////////////////////////////
	// Console characters
	//////////////////////////////

	localparam logic [7:0] KEY_ENTER  = 8'h0d;
	localparam logic [7:0] KEY_DEC    = 8'h31;
	localparam logic [7:0] KEY_INC    = 8'h32;
	localparam logic [7:0] CHAR_SPACE = 8'h20;
	localparam logic [7:0] ASCII_ZERO = 8'h30;

	// Dump stops once the cursor gets here
	localparam logic [7:0] DUMP_LIMIT = 8'd10;

	// SPART register map
	localparam logic [1:0] IOADDR_DATA    = 2'd0;
	localparam logic [1:0] IOADDR_DB_LOW  = 2'd2;
	localparam logic [1:0] IOADDR_DB_HIGH = 2'd3;

	// Divisor bytes per br_cfg: 4800, 9600, 19200, 38400
	localparam logic [7:0] BAUD_DB_LOW  [4] = '{8'hc0, 8'h80, 8'h00, 8'h00};
	localparam logic [7:0] BAUD_DB_HIGH [4] = '{8'h12, 8'h25, 8'h4b, 8'h96};

endpackage

`default_nettype wire
